//--- testbench/ni_input.txt
# Each line holds samples ch0 to ch7 followed by sum and expected mask in hex
# Mask bit k is set when channel k is above gain times sum
0003E9 0003E8 0003E7 000000 FFFFFF 0003E8 001000 0003E9 028 D1
000000 000001 000000 800000 000000 000000 000002 FFFFFF 000 CA
0063E7 0063E8 0063E6 FFFFFF 000000 0063E7 010000 0063E7 3FF 4A
000065 000065 000065 000065 000065 000065 000065 000065 004 FF
000064 000064 000064 000064 000064 000064 000064 000064 004 00
002711 00270F 002710 002711 002710 002711 00270F 002711 190 A9
000190 000191 000190 000191 000190 000191 000190 000191 010 AA
0009C5 0009C4 0009C5 0009C4 0009C5 0009C4 0009C5 0009C4 064 55
00001A 000019 000018 000000 00001A 00001A 000019 00FFFF 001 B1
000033 000033 000032 000032 000031 000031 000033 000033 002 C3
0000FA 0000FA 0000FB 0000FB 0000FB 0000FB 0000FA 0000FA 00A 3C
0001F5 0001F4 0001F4 0001F4 0001F4 0001F4 0001F4 0001F4 014 01
0001F4 0001F4 0001F4 0001F4 0001F4 0001F4 0001F4 0001F5 014 80
0007D0 0007D1 0007D0 0007D0 0007D0 0007D0 0007D0 0007D0 050 02
0007D0 0007D0 0007D0 0007D0 0007D0 0007D0 0007D1 0007D0 050 40
0000C8 0000C8 0000C9 0000C8 0000C8 0000C8 0000C8 0000C8 008 04
0000C8 0000C8 0000C8 0000C8 0000C8 0000C9 0000C8 0000C8 008 20
003200 003200 003200 003201 003200 003200 003200 003200 200 08
003200 003200 003200 003200 003201 003200 003200 003200 200 10
001901 001901 001901 001901 0018FF 0018FF 0018FF 0018FF 100 0F
0018FF 0018FF 0018FF 0018FF 001901 001901 001901 001901 100 F0
000C81 000C7F 000C81 000C7F 000C80 000C81 000C80 000C81 080 A5
000641 000641 000640 000640 000641 000641 000640 000640 040 33
000320 000320 000321 000321 000320 000320 000321 000321 020 CC
FFFFFF FFFFFF FFFFFF FFFFFF FFFFFF FFFFFF FFFFFF FFFFFF 3FF FF
0063E7 0063E7 0063E7 0063E7 0063E7 0063E7 0063E7 0063E7 3FF 00
000000 000000 000000 000000 000000 000000 000000 000000 000 00
000001 000001 000001 000001 000001 000001 000001 000001 000 FF
7FFFFF 0003E8 123456 0003E7 000ABC 0003E8 0003E9 000001 028 55
0061A9 0061A8 0061A7 0061A9 0061A8 0061A8 0061A9 0061A8 3E8 49
001388 001389 001389 001389 001388 001387 001389 001388 0C8 4E
00012D 00012C 00012D 00012D 00012D 00012C 00012D 00012D 00C DD
0030D5 0030D4 0030D5 0030D5 0030D5 0030D5 0030D5 0030D4 1F4 7D
00007D 00007E 00007E 00007E 00007E 00007E 00007E 00007E 005 FE

//--- all.f
+incdir+design
design/ni_pkg.sv
design/ni_wb_regs.sv
design/ni_calc.sv
design/ni_collect.sv
design/ni.sv
testbench/tb_ni.sv

//--- Bender.yml
package:
  name: ni

export_include_dirs:
  - design

sources:
  - include_dirs:
      - design
    files:
      - design/ni_pkg.sv
      - design/ni_wb_regs.sv
      - design/ni_calc.sv
      - design/ni_collect.sv
      - design/ni.sv
  - target: test
    include_dirs:
      - design
    files:
      - testbench/tb_ni.sv

//--- testbench/tb_ni.sv
`timescale 1ns/10ps
`include "ni_params.svh"

module tb_ni;

  localparam int ACK_LIMIT  = 16;   // Cycles to wait for ack
  localparam int POLL_LIMIT = 100;  // STATUS reads before giving up on done
  localparam int CNT_W      = $clog2(`NI_CHANNELS + 1);

  typedef struct packed {
    logic [`NI_CHANNELS-1:0][`NI_SAMPLE_W-1:0] sample;
    logic [`NI_WIDTH-1:0]                      sum;
    logic [`NI_CHANNELS-1:0]                   mask;
  } job_rec_t;

  logic            clk;
  logic            rst_n;
  ni_pkg::wb_req_t wb_req;
  ni_pkg::wb_rsp_t wb_rsp;

  integer   seed;
  int       errors;
  int       checks;
  bit       timed_out;
  job_rec_t jobs [$];

  ni dut (
    .clk      (clk),
    .rst_n    (rst_n),
    .wb_req_i (wb_req),
    .wb_rsp_o (wb_rsp)
  );

  always #2 clk = ~clk;

  //////////////////////////////
  // Reference model

  // Channel bit is set only when the sample is above gain times sum
  function automatic logic [`NI_CHANNELS-1:0] rule_mask(input job_rec_t j);
    logic [`NI_CHANNELS-1:0] m;
    m = '0;
    for (int k = 0; k < `NI_CHANNELS; k++) begin
      m[k] = longint'(j.sample[k]) > (longint'(j.sum) * `NI_GAIN);
    end
    return m;
  endfunction

  function automatic int ones_in(input logic [`NI_CHANNELS-1:0] m);
    int n;
    n = 0;
    for (int k = 0; k < `NI_CHANNELS; k++) begin
      n += m[k];
    end
    return n;
  endfunction

  //////////////////////////////
  // Wishbone master

  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic idle_gap();
    int gap;
    gap = $random(seed) & 3;
    repeat (gap) next_cycle();
  endtask

  task automatic write_reg(input logic [`NI_WB_AW-1:0] adr, input logic [`NI_WB_DW-1:0] dat);
    int waited;
    if (!timed_out) begin
      wb_req.cyc = 1'b1;
      wb_req.stb = 1'b1;
      wb_req.we  = 1'b1;
      wb_req.adr = adr;
      wb_req.dat = dat;
      waited = 0;
      next_cycle();
      while (!wb_rsp.ack && waited < ACK_LIMIT) begin
        next_cycle();
        waited++;
      end
      if (!wb_rsp.ack) begin
        $display("No ack came for the write to address %h", adr);
        errors++;
        timed_out = 1'b1;
      end
      next_cycle();  // Slave takes the data at the end of the ack cycle
      wb_req = '0;
    end
  endtask

  task automatic read_reg(input logic [`NI_WB_AW-1:0] adr, output logic [`NI_WB_DW-1:0] dat);
    int waited;
    dat = 'x;
    if (!timed_out) begin
      wb_req.cyc = 1'b1;
      wb_req.stb = 1'b1;
      wb_req.we  = 1'b0;
      wb_req.adr = adr;
      wb_req.dat = '0;
      waited = 0;
      next_cycle();
      while (!wb_rsp.ack && waited < ACK_LIMIT) begin
        next_cycle();
        waited++;
      end
      if (wb_rsp.ack) begin
        dat = wb_rsp.dat;
      end else begin
        $display("No ack came for the read of address %h", adr);
        errors++;
        timed_out = 1'b1;
      end
      next_cycle();
      wb_req = '0;
    end
  endtask

  task automatic wait_done();
    logic [`NI_WB_DW-1:0] status;
    int                   polls;
    status = '0;
    polls  = 0;
    while (!timed_out && status[1] !== 1'b1 && polls < POLL_LIMIT) begin
      read_reg(ni_pkg::STATUS, status);
      polls++;
    end
    if (!timed_out && status[1] !== 1'b1) begin
      $display("Job did not report done within %0d STATUS reads", polls);
      errors++;
      timed_out = 1'b1;
    end
  endtask

  //////////////////////////////
  // Test steps

  task automatic load_jobs();
    int                   fd;
    int                   n;
    string                line;
    logic [`NI_WB_DW-1:0] f [10];
    job_rec_t             j;
    fd = $fopen("testbench/ni_input.txt", "r");
    if (fd == 0) begin
      $display("Could not open testbench/ni_input.txt");
      errors++;
    end else begin
      while (!$feof(fd)) begin
        line = "";
        n = $fgets(line, fd);
        if (n > 0 && line.len() > 1 && line.getc(0) != "#") begin  // Skip comments
          n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h",
                      f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9]);
          if (n != 10) begin
            $display("Malformed job line in the input file: %s", line);
            errors++;
          end else begin
            for (int k = 0; k < `NI_CHANNELS; k++) begin
              j.sample[k] = f[k][`NI_SAMPLE_W-1:0];
            end
            j.sum  = f[`NI_CHANNELS][`NI_WIDTH-1:0];
            j.mask = f[`NI_CHANNELS + 1][`NI_CHANNELS-1:0];
            jobs.push_back(j);
          end
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic check_readback();
    logic [`NI_WB_DW-1:0] wdat;
    logic [`NI_WB_DW-1:0] rdat;
    logic [`NI_WB_DW-1:0] exp;
    for (int k = 0; k < `NI_CHANNELS && !timed_out; k++) begin
      wdat = $random(seed);
      exp  = `NI_WB_DW'(wdat[`NI_SAMPLE_W-1:0]);
      write_reg(`NI_WB_AW'(4 * k), wdat);
      idle_gap();
      read_reg(`NI_WB_AW'(4 * k), rdat);
      checks++;
      if (rdat !== exp) begin
        $display("error at %0d ns: CH%0d got %h, expected %h", $time, k, rdat, exp);
        errors++;
      end
    end
    wdat = $random(seed);
    exp  = `NI_WB_DW'(wdat[`NI_WIDTH-1:0]);
    write_reg(ni_pkg::SUM, wdat);
    read_reg(ni_pkg::SUM, rdat);
    checks++;
    if (rdat !== exp) begin
      $display("error at %0d ns: SUM got %h, expected %h", $time, rdat, exp);
      errors++;
    end
  endtask

  task automatic run_job(input job_rec_t j, input bit double_start);
    logic [`NI_WB_DW-1:0]    rdat;
    logic [`NI_CHANNELS-1:0] rule;
    if (!timed_out) begin
      rule = rule_mask(j);
      checks++;
      if (rule !== j.mask) begin
        $display("error at %0d ns: input file mask got %h, expected %h", $time, j.mask, rule);
        errors++;
      end
      for (int k = 0; k < `NI_CHANNELS; k++) begin
        write_reg(`NI_WB_AW'(4 * k), `NI_WB_DW'(j.sample[k]));
        idle_gap();
      end
      write_reg(ni_pkg::SUM, `NI_WB_DW'(j.sum));
      idle_gap();
      write_reg(ni_pkg::CTRL, `NI_WB_DW'(1));
      if (double_start) begin
        // Channel 0 flips its bit, so an accepted restart would change the mask
        write_reg(ni_pkg::CH0, j.mask[0] ? `NI_WB_DW'(0) : `NI_WB_DW'(24'hFFFFFF));
        write_reg(ni_pkg::CTRL, `NI_WB_DW'(1));  // Lands before the first job leaves BUSY
      end
      wait_done();
      read_reg(ni_pkg::RESULT, rdat);
      checks += 2;
      if (rdat[`NI_CHANNELS-1:0] !== j.mask) begin
        $display("error at %0d ns: RESULT.mask got %h, expected %h",
                 $time, rdat[`NI_CHANNELS-1:0], j.mask);
        errors++;
      end
      if (rdat[`NI_CHANNELS +: CNT_W] !== CNT_W'(ones_in(j.mask))) begin
        $display("error at %0d ns: RESULT.count got %0d, expected %0d",
                 $time, rdat[`NI_CHANNELS +: CNT_W], ones_in(j.mask));
        errors++;
      end
    end
  endtask

  task automatic check_unmapped();
    logic [`NI_WB_AW-1:0] addrs [4];
    logic [`NI_WB_DW-1:0] rdat;
    addrs = '{8'h02, 8'h30, 8'h80, 8'hFC};
    foreach (addrs[i]) begin
      read_reg(addrs[i], rdat);
      checks++;
      if (rdat !== '0) begin
        $display("error at %0d ns: unmapped %h got %h, expected %h", $time, addrs[i], rdat, 0);
        errors++;
      end
    end
  endtask

  //////////////////////////////
  // Main sequence

  initial begin
    logic [`NI_WB_DW-1:0] rdat;
    clk       = 1'b0;
    rst_n     = 1'b0;
    wb_req    = '0;
    seed      = 82025;
    errors    = 0;
    checks    = 0;
    timed_out = 1'b0;
    load_jobs();
    if (jobs.size() < 2) begin
      $display("Input file gave %0d jobs, at least two are needed", jobs.size());
      errors++;
    end
    repeat (10) @(posedge clk);
    #1;
    rst_n = 1'b1;
    next_cycle();

    read_reg(ni_pkg::STATUS, rdat);
    checks++;
    if (rdat !== '0) begin
      $display("error at %0d ns: STATUS got %h, expected %h", $time, rdat, 0);
      errors++;
    end
    check_readback();
    foreach (jobs[i]) begin
      run_job(jobs[i], 1'b0);
    end
    // Restart while busy, then a fresh job with other channels
    if (jobs.size() >= 2) begin
      run_job(jobs[0], 1'b1);
      run_job(jobs[1], 1'b0);
    end
    check_unmapped();

    $display("Checks %0d, errors %0d, timeout %0d", checks, errors, timed_out);
    if (errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

//--- design/ni.sv
`timescale 1ns/10ps
`include "ni_params.svh"

module ni (
  input  logic            clk,
  input  logic            rst_n,
  input  ni_pkg::wb_req_t wb_req_i,
  output ni_pkg::wb_rsp_t wb_rsp_o
);

  ni_pkg::ni_job_t [`NI_CHANNELS-1:0] job;
  ni_pkg::ni_bit_t [`NI_CHANNELS-1:0] bits;
  ni_pkg::ni_result_t                 result;

  //////////////////////////////
  // Host side

  ni_wb_regs u_regs (
    .clk      (clk),
    .rst_n    (rst_n),
    .wb_req_i (wb_req_i),
    .wb_rsp_o (wb_rsp_o),
    .result_i (result),
    .job_o    (job)
  );

  //////////////////////////////
  // Threshold cells

  // One cell per channel, all fed the same sum and start
  for (genvar g = 0; g < `NI_CHANNELS; g++) begin : g_cell
    ni_calc #(
      .WIDTH (`NI_WIDTH),
      .GAIN  (`NI_GAIN)
    ) u_calc (
      .clk   (clk),
      .rst_n (rst_n),
      .job_i (job[g]),
      .bit_o (bits[g])
    );
  end

  //////////////////////////////
  // Drain

  ni_collect u_collect (
    .clk      (clk),
    .rst_n    (rst_n),
    .bits_i   (bits),
    .result_o (result)
  );

endmodule

//--- design/ni_collect.sv
`timescale 1ns/10ps
`include "ni_params.svh"

module ni_collect (
  input  logic                               clk,
  input  logic                               rst_n,
  input  ni_pkg::ni_bit_t [`NI_CHANNELS-1:0] bits_i,
  output ni_pkg::ni_result_t                 result_o
);

  localparam int CNT_W = $clog2(`NI_CHANNELS + 1);

  logic [`NI_CHANNELS-1:0] valid_vec;
  logic [`NI_CHANNELS-1:0] bit_vec;
  logic                    all_valid;
  logic [CNT_W-1:0]        ones;
  logic                    valid_q;
  logic [`NI_CHANNELS-1:0] mask_q;
  logic [CNT_W-1:0]        count_q;

  // Cell k lands in mask bit k
  always_comb begin
    ones = '0;
    for (int k = 0; k < `NI_CHANNELS; k++) begin
      valid_vec[k] = bits_i[k].valid;
      bit_vec[k]   = bits_i[k].value;
      ones         = ones + CNT_W'(bits_i[k].value);
    end
  end

  assign all_valid = &valid_vec;

  //////////////////////////////
  // Result hold

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= all_valid;  // Single cycle pulse since cell valids last one cycle
    end
  end

  always_ff @(posedge clk) begin
    if (all_valid) begin
      mask_q  <= bit_vec;
      count_q <= ones;
    end
  end

  assign result_o.valid = valid_q;
  assign result_o.mask  = mask_q;
  assign result_o.count = count_q;

endmodule

//--- design/ni_calc.sv
`timescale 1ns/10ps
`include "ni_params.svh"

module ni_calc #(
  parameter int WIDTH = `NI_WIDTH,
  parameter int GAIN  = `NI_GAIN
) (
  input  logic               clk,
  input  logic               rst_n,
  input  ni_pkg::ni_job_t    job_i,
  output ni_pkg::ni_bit_t    bit_o
);

  logic [WIDTH-1:0]        sum_w;
  logic [`NI_SAMPLE_W-1:0] sample_q;
  logic [`NI_PROD_W-1:0]   prod_q;
  logic                    stage_q;
  logic                    valid_q;
  logic                    hit_q;

  assign sum_w = WIDTH'(job_i.sum);  // Cell may run narrower or wider than the bus sum

  //////////////////////////////
  // Two stage pipeline

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      stage_q <= 1'b0;
      valid_q <= 1'b0;
    end else begin
      stage_q <= job_i.start;
      valid_q <= stage_q;
    end
  end

  always_ff @(posedge clk) begin
    if (job_i.start) begin
      sample_q <= job_i.sample;
      prod_q   <= `NI_PROD_W'(sum_w) * `NI_PROD_W'(GAIN);
    end
    // Strict compare so a sample equal to the threshold gives 0
    if (stage_q) begin
      hit_q <= `NI_PROD_W'(sample_q) > prod_q;
    end
  end

  assign bit_o.valid = valid_q;
  assign bit_o.value = hit_q;

endmodule

//--- design/ni_wb_regs.sv
`timescale 1ns/10ps
`include "ni_params.svh"

module ni_wb_regs (
  input  logic                               clk,
  input  logic                               rst_n,
  input  ni_pkg::wb_req_t                    wb_req_i,
  output ni_pkg::wb_rsp_t                    wb_rsp_o,
  input  ni_pkg::ni_result_t                 result_i,
  output ni_pkg::ni_job_t [`NI_CHANNELS-1:0] job_o
);

  localparam int CH_IW = $clog2(`NI_CHANNELS);
  localparam int CNT_W = $clog2(`NI_CHANNELS + 1);

  logic                    ack_q;
  logic [`NI_WB_DW-1:0]    rdata_q;
  logic [`NI_WB_DW-1:0]    rdata;
  logic [`NI_SAMPLE_W-1:0] ch_q [`NI_CHANNELS];
  logic [`NI_WIDTH-1:0]    sum_q;
  logic                    start_q;
  ni_pkg::ni_state_e       state_q;
  logic [`NI_CHANNELS-1:0] mask_q;
  logic [CNT_W-1:0]        count_q;
  logic                    access;
  logic                    wr_ack;
  logic                    ch_hit;
  logic [CH_IW-1:0]        ch_idx;
  logic                    start_req;

  //////////////////////////////
  // Bus decode

  // New cycle seen; ack follows on the next edge
  assign access = wb_req_i.cyc && wb_req_i.stb && !ack_q;

  // Writes land during the ack cycle while the master still holds the request
  assign wr_ack = ack_q && wb_req_i.cyc && wb_req_i.stb && wb_req_i.we;

  assign ch_hit = (wb_req_i.adr[1:0] == 2'b00) && (wb_req_i.adr <= ni_pkg::CH7);
  assign ch_idx = wb_req_i.adr[2 +: CH_IW];

  // A start while busy is dropped
  assign start_req = wr_ack && (wb_req_i.adr == ni_pkg::CTRL) && wb_req_i.dat[0] &&
                     (state_q != ni_pkg::BUSY);

  always_comb begin
    rdata = '0;
    if (ch_hit) begin
      rdata = `NI_WB_DW'(ch_q[ch_idx]);
    end else begin
      case (wb_req_i.adr)
        ni_pkg::SUM:    rdata = `NI_WB_DW'(sum_q);
        ni_pkg::STATUS: rdata = `NI_WB_DW'({state_q == ni_pkg::DONE, state_q == ni_pkg::BUSY});
        ni_pkg::RESULT: rdata = `NI_WB_DW'({count_q, mask_q});
        default:        rdata = '0;  // CTRL is write only
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= access;
    end
  end

  always_ff @(posedge clk) begin
    if (access) begin
      rdata_q <= rdata;
    end
  end

  assign wb_rsp_o.ack = ack_q;
  assign wb_rsp_o.dat = rdata_q;

  //////////////////////////////
  // Register file

  always_ff @(posedge clk) begin
    if (wr_ack && ch_hit) begin
      ch_q[ch_idx] <= wb_req_i.dat[`NI_SAMPLE_W-1:0];
    end
    if (wr_ack && (wb_req_i.adr == ni_pkg::SUM)) begin
      sum_q <= wb_req_i.dat[`NI_WIDTH-1:0];
    end
  end

  //////////////////////////////
  // Job control

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state_q <= ni_pkg::IDLE;
      start_q <= 1'b0;
    end else begin
      start_q <= start_req;
      case (state_q)
        ni_pkg::IDLE,
        ni_pkg::DONE: begin
          if (start_req) begin
            state_q <= ni_pkg::BUSY;
          end
        end
        ni_pkg::BUSY: begin
          if (result_i.valid) begin
            state_q <= ni_pkg::DONE;
          end
        end
        default: state_q <= ni_pkg::IDLE;
      endcase
    end
  end

  // Result stays readable until the next job finishes
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      mask_q  <= '0;
      count_q <= '0;
    end else if ((state_q == ni_pkg::BUSY) && result_i.valid) begin
      mask_q  <= result_i.mask;
      count_q <= result_i.count;
    end
  end

  // Cells latch sample and sum on the start pulse, so later writes leave the job alone
  always_comb begin
    for (int k = 0; k < `NI_CHANNELS; k++) begin
      job_o[k].start  = start_q;
      job_o[k].sample = ch_q[k];
      job_o[k].sum    = sum_q;
    end
  end

endmodule

//--- design/ni_pkg.sv
`include "ni_params.svh"

package ni_pkg;

  //////////////////////////////
  // Wishbone classic

  typedef struct packed {
    logic                 cyc;
    logic                 stb;
    logic                 we;
    logic [`NI_WB_AW-1:0] adr;
    logic [`NI_WB_DW-1:0] dat;
  } wb_req_t;

  typedef struct packed {
    logic                 ack;
    logic [`NI_WB_DW-1:0] dat;
  } wb_rsp_t;

  //////////////////////////////
  // Cell traffic

  typedef struct packed {
    logic                    start;  // One cycle pulse shared by all cells
    logic [`NI_SAMPLE_W-1:0] sample;
    logic [`NI_WIDTH-1:0]    sum;
  } ni_job_t;

  typedef struct packed {
    logic valid;
    logic value;  // Sample above threshold
  } ni_bit_t;

  typedef struct packed {
    logic                                valid;
    logic [`NI_CHANNELS-1:0]             mask;
    logic [$clog2(`NI_CHANNELS + 1)-1:0] count;
  } ni_result_t;

  typedef enum logic [1:0] {
    IDLE,
    BUSY,
    DONE
  } ni_state_e;

  typedef enum logic [`NI_WB_AW-1:0] {
    CH0    = 8'h00,
    CH1    = 8'h04,
    CH2    = 8'h08,
    CH3    = 8'h0C,
    CH4    = 8'h10,
    CH5    = 8'h14,
    CH6    = 8'h18,
    CH7    = 8'h1C,
    SUM    = 8'h20,
    CTRL   = 8'h24,
    STATUS = 8'h28,
    RESULT = 8'h2C
  } ni_reg_e;

endpackage

//--- design/ni_params.svh
`ifndef NI_PARAMS_SVH
`define NI_PARAMS_SVH

//////////////////////////////
// Datapath sizes

// Number of threshold cells, one per channel
`define NI_CHANNELS 8

// Width of one channel sample
`define NI_SAMPLE_W 24

// Width of the reference sum
`define NI_WIDTH 10

// Default multiplier applied to the sum before the compare
`define NI_GAIN 25

// Product register width. Holds sum times gain without overflow
`define NI_PROD_W 32

//////////////////////////////
// Wishbone sizes

`define NI_WB_AW 8  // Byte address
`define NI_WB_DW 32

`endif
